// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_minimig_board
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk_28
);

  localparam real half_period = 4.0;  // 8 ns period

  initial begin
    clk_28 = 1'b0;
  end

  always #(half_period) clk_28 = ~clk_28;

endmodule

// ==== tests/tb_checks.svh ====
//////////////////////////////////////////////////
// Check counters
//////////////////////////////////////////////////

int checks      = 0;  // Compares done
int errors      = 0;  // Compares failed
int tests       = 0;
int test_errors = 0;  // Errors at start of current test

task automatic check_mdat(input string name, input mdat_t got, input mdat_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_led(input string name, input led_t got, input led_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s got %h expected %h", name, got, exp);
  end
endtask

// Cycle and access counts
task automatic check_count(input string name, input int got, input int exp);
  checks++;
  if (got != exp) begin
    errors++;
    $display("error %s got %h expected %h", name, got, exp);
  end
endtask

task automatic finish_test(input string name);
  tests++;
  $display("test %s done with %0d errors", name, errors - test_errors);
  test_errors = errors;
endtask

// Ends the run at once
task automatic report_timeout(input string what);
  $display("timeout after 200 cycles waiting for %s", what);
  $display("TEST FAIL");
  $finish;
endtask

// ==== tests/tb_minimig_board.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module tb_minimig_board
  import board_pkg::*;
();

  logic clk_28;
  logic rst, pll_locked;
  sw_t sw;
  key_t key;
  logic uart_rxd, ctrl_txd, minimig_txd, sd_dat, minimig_sdo;
  logic [3:0] spi_cs_n;
  logic uart_txd, ctrl_rxd, minimig_rxd, spi_di, sd_dat3;
  logic scan_15khz, audio_swap, audio_mix;
  logic rst_sys, rst_minimig, rst_cpu;
  logic m_cs, m_we, m_ack, m_err;
  qmem_adr_t m_adr, s_adr;
  msel_t m_sel;
  mdat_t m_dat_w, m_dat_r;
  sdat_t s_dat_r, s_dat_w;
  logic s_ack, s_err, s_cs, s_we;
  ssel_t s_sel;
  logic floppy_fwr, floppy_frd, hd_fwr, hd_frd, fifo_full;
  led_t led_g;

  integer seed = 31;
  int slave_acks;        // Halfword accesses answered
  sdat_t smem [int];     // Slave halfword store
  mdat_t wmem [int];     // Reference word model

  `include "tb_checks.svh"

  clk_gen clk_gen (.clk_28(clk_28));

  minimig_board_top UUT (.*);

  //////////////////////////////////////////////////
  // Slave memory model
  //////////////////////////////////////////////////

  initial begin
    int d;
    int idx;
    qmem_adr_t adr;
    logic we;
    ssel_t sel;
    sdat_t wd, cur;
    forever begin
      @(negedge clk_28);
      if (s_cs === 1'b1) begin
        adr = s_adr;  // Held until ack
        we  = s_we;
        sel = s_sel;
        wd  = s_dat_w;
        idx = int'(adr >> 1);
        d   = ($random(seed) & 32'h7fffffff) % 5;
        repeat (d) @(posedge clk_28);
        @(posedge clk_28);
        cur = smem.exists(idx) ? smem[idx] : '0;
        if (we) begin
          if (sel[1]) cur[15:8] = wd[15:8];
          if (sel[0]) cur[7:0] = wd[7:0];
          smem[idx] = cur;
        end
        s_dat_r <= cur;
        s_err   <= adr[`BOARD_AW-1];  // Top half of space faults
        s_ack   <= 1'b1;
        slave_acks++;
        @(posedge clk_28);
        s_ack <= 1'b0;
        s_err <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Master access
  //////////////////////////////////////////////////

  task automatic run_access(input logic we, input qmem_adr_t adr, input msel_t sel,
                            input mdat_t wdat, output mdat_t rdat, output logic err,
                            output int lat, output logic cs_seen);
    int n;
    n = 0;
    cs_seen = 1'b0;
    slave_acks = 0;
    @(posedge clk_28);
    m_cs    <= 1'b1;
    m_we    <= we;
    m_adr   <= adr;
    m_sel   <= sel;
    m_dat_w <= wdat;
    do begin
      @(posedge clk_28);
      n++;
      @(negedge clk_28);
      if (s_cs === 1'b1) cs_seen = 1'b1;
      if (n > 200) report_timeout("m_ack");
    end while (m_ack !== 1'b1);
    rdat = m_dat_r;
    err  = m_err;
    lat  = n;
    @(posedge clk_28);
    m_cs <= 1'b0;  // Drop on the cycle after ack
  endtask

  // Halfwords touched by a select pattern
  function automatic int halves(input msel_t sel);
    return int'(sel[3:2] != 2'b00) + int'(sel[1:0] != 2'b00);
  endfunction

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int n, k, m, idx;
    logic p_prev, p_next, err, cs_seen, v;
    qmem_adr_t adr;
    msel_t sel;
    mdat_t wdat, rdat, exp, word;
    rst         = 1'b1;
    pll_locked  = 1'b1;
    sw          = '0;
    key         = 2'b11;
    uart_rxd    = 1'b1;
    ctrl_txd    = 1'b1;
    minimig_txd = 1'b1;
    sd_dat      = 1'b0;
    minimig_sdo = 1'b0;
    spi_cs_n    = 4'hf;
    m_cs        = 1'b0;
    m_we        = 1'b0;
    m_adr       = '0;
    m_sel       = '0;
    m_dat_w     = '0;
    s_dat_r     = '0;
    s_ack       = 1'b0;
    s_err       = 1'b0;
    floppy_fwr  = 1'b0;
    floppy_frd  = 1'b0;
    hd_fwr      = 1'b0;
    hd_frd      = 1'b0;
    fifo_full   = 1'b0;
    repeat (8) @(posedge clk_28);
    rst <= 1'b0;

    // Reset release timing
    n = 0;
    do begin
      @(posedge clk_28);
      n++;
      @(negedge clk_28);
      if (n > 200) report_timeout("rst_minimig release");
    end while (rst_minimig !== 1'b0);
    check_count("rst_minimig hold", n, `BOARD_RST_HOLD);
    check_bit("rst_cpu", rst_cpu, 1'b1);
    n = 0;
    do begin
      @(posedge clk_28);
      n++;
      @(negedge clk_28);
      if (n > 200) report_timeout("rst_cpu release");
    end while (rst_cpu !== 1'b0);
    check_count("rst_cpu hold", n, `BOARD_CPU_HOLD);
    check_bit("rst_sys", rst_sys, 1'b0);
    @(posedge clk_28);
    pll_locked <= 1'b0;
    @(posedge clk_28);
    @(negedge clk_28);
    check_bit("rst_sys", rst_sys, 1'b1);
    check_bit("rst_minimig", rst_minimig, 1'b1);
    check_bit("rst_cpu", rst_cpu, 1'b1);
    @(posedge clk_28);
    @(negedge clk_28);
    check_led("led_g", led_g, 8'h60);  // Both reset LEDs on
    @(posedge clk_28);
    pll_locked <= 1'b1;
    n = 0;
    do begin
      @(posedge clk_28);
      n++;
      @(negedge clk_28);
      if (n > 200) report_timeout("rst_cpu after pll relock");
    end while (rst_cpu !== 1'b0);
    @(posedge clk_28);
    @(negedge clk_28);
    check_led("led_g", led_g, 8'h00);
    finish_test("reset release");

    // Random write then read back
    for (int i = 0; i < 50; i++) begin
      adr  = qmem_adr_t'($random(seed) & 32'hff);
      sel  = msel_t'($random(seed));
      wdat = mdat_t'($random(seed));
      idx  = int'(adr >> 2);
      run_access(1'b1, adr, sel, wdat, rdat, err, n, cs_seen);
      check_bit("m_err", err, 1'b0);
      check_count("slave accesses", slave_acks, halves(sel));
      word = wmem.exists(idx) ? wmem[idx] : '0;
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) word[b*8 +: 8] = wdat[b*8 +: 8];
      end
      wmem[idx] = word;
      run_access(1'b0, adr, sel, '0, rdat, err, n, cs_seen);
      exp = '0;
      if (sel[3:2] != 2'b00) exp[31:16] = word[31:16];
      if (sel[1:0] != 2'b00) exp[15:0] = word[15:0];
      check_mdat("m_dat_r", rdat, exp);
      check_bit("m_err", err, 1'b0);
      check_count("slave accesses", slave_acks, halves(sel));
    end
    finish_test("bridge write read");

    // Error flag and empty selects
    adr = qmem_adr_t'(32'h400000 | ($random(seed) & 32'hfc));
    run_access(1'b1, adr, 4'hf, 32'h12345678, rdat, err, n, cs_seen);
    check_bit("m_err", err, 1'b1);
    check_count("slave accesses", slave_acks, 2);
    run_access(1'b0, adr, 4'h3, '0, rdat, err, n, cs_seen);
    check_bit("m_err", err, 1'b1);
    run_access(1'b0, qmem_adr_t'(8), 4'h0, '0, rdat, err, n, cs_seen);
    check_count("empty select latency", n, 2);
    check_bit("s_cs seen", cs_seen, 1'b0);
    check_bit("m_err", err, 1'b0);
    check_mdat("m_dat_r", rdat, '0);
    finish_test("bridge errors");

    // LED stretch with a restart mid-window
    repeat (`BOARD_LED_HOLD) @(posedge clk_28);  // Bridge activity LED runs out
    @(negedge clk_28);
    check_led("led_g", led_g, 8'h00);
    p_prev = 1'b0;
    m = 0;
    for (k = 0; k < 70; k++) begin
      @(posedge clk_28);
      if (p_prev) m = `BOARD_LED_HOLD;
      else if (m != 0) m--;
      p_next = (k == 0) || (k == 20);
      floppy_frd <= p_next;
      p_prev = p_next;
      @(negedge clk_28);
      check_led("led_g", led_g, {6'b0, m != 0, 1'b0});
    end
    finish_test("led stretch");

    // UART, SPI and config routing
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_28);
      sw          <= sw_t'($random(seed));
      spi_cs_n    <= 4'($random(seed));
      uart_rxd    <= 1'($random(seed));
      ctrl_txd    <= 1'($random(seed));
      minimig_txd <= 1'($random(seed));
      sd_dat      <= 1'($random(seed));
      minimig_sdo <= 1'($random(seed));
      @(posedge clk_28);
      @(posedge clk_28);
      @(negedge clk_28);
      v = sw[0];
      check_bit("uart_txd", uart_txd, v ? ctrl_txd : minimig_txd);
      check_bit("ctrl_rxd", ctrl_rxd, v ? uart_rxd : 1'b1);
      check_bit("minimig_rxd", minimig_rxd, v ? 1'b1 : uart_rxd);
      check_bit("spi_di", spi_di, spi_cs_n[0] ? minimig_sdo : sd_dat);
      check_bit("sd_dat3", sd_dat3, spi_cs_n[0]);
      check_bit("scan_15khz", scan_15khz, sw[1]);
      check_bit("audio_swap", audio_swap, sw[2]);
      check_bit("audio_mix", audio_mix, sw[3]);
    end
    finish_test("routing");

    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+tests
verilog/board_pkg.sv
verilog/board_io.sv
verilog/reset_sequencer.sv
verilog/qmem_bridge.sv
verilog/activity_leds.sv
verilog/minimig_board_top.sv
tests/clk_gen.sv
tests/tb_minimig_board.sv

// ==== verilog/activity_leds.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module activity_leds
  import board_pkg::*;
(
  input  logic clk_28,
  input  logic rst,
  input  logic floppy_fwr,   // Floppy FIFO write
  input  logic floppy_frd,   // Floppy FIFO read
  input  logic hd_fwr,       // HD FIFO write
  input  logic hd_frd,       // HD FIFO read
  input  logic dram_active,  // Bridge slave cycle
  input  logic rst_minimig,
  input  logic rst_cpu,
  input  logic fifo_full,
  output led_t led_g
);

  localparam int n_str = 5;                           // Stretched LEDs
  localparam int cnt_w = $clog2(`BOARD_LED_HOLD + 1);

  localparam logic [cnt_w-1:0] hold_val = cnt_w'(`BOARD_LED_HOLD);

  logic [n_str-1:0] pulse;
  logic [cnt_w-1:0] cnt [n_str];  // Remaining lit cycles
  logic [n_str-1:0] lit;
  logic [2:0]       status_q;     // Registered direct LEDs

  // LED bit order 0..4
  assign pulse = {dram_active, hd_frd, hd_fwr, floppy_frd, floppy_fwr};

  //////////////////////////////////////////////////
  // Pulse stretchers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      for (int i = 0; i < n_str; i++) begin
        cnt[i] <= '0;
      end
      status_q <= '0;
    end else begin
      for (int i = 0; i < n_str; i++) begin
        if (pulse[i]) begin
          cnt[i] <= hold_val;        // Restart on every pulse
        end else if (cnt[i] != '0) begin
          cnt[i] <= cnt[i] - 1'b1;
        end
      end
      status_q <= {fifo_full, rst_cpu, rst_minimig};
    end
  end

  always_comb begin
    for (int i = 0; i < n_str; i++) begin
      lit[i] = (cnt[i] != '0);
    end
  end

  //////////////////////////////////////////////////
  // LED map
  //////////////////////////////////////////////////

  assign led_g = {status_q, lit};  // 7 fifo_full, 6 rst_cpu, 5 rst_minimig

endmodule

// ==== verilog/board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

//////////////////////////////////////////////////
// qmem bus widths
//////////////////////////////////////////////////

`define BOARD_AW          23  // Byte address width
`define BOARD_MDW         32  // Control side data word
`define BOARD_SDW         16  // SDRAM side halfword

//////////////////////////////////////////////////
// Board timing
//////////////////////////////////////////////////

`define BOARD_SYNC_STAGES 2   // Flops per input synchronizer

// Core reset hold after the last cause is gone
`define BOARD_RST_HOLD    16
// Extra cycles before the CPU may run
`define BOARD_CPU_HOLD    16

`define BOARD_LED_HOLD    32  // Visible LED stretch in cycles

`endif

// ==== verilog/board_io.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module board_io
  import board_pkg::*;
(
  input  logic       clk_28,
  input  logic       rst,
  input  sw_t        sw,           // Raw switches
  input  key_t       key,          // Raw keys
  input  logic       uart_rxd,     // Board UART receive pin
  input  logic       ctrl_txd,     // ctrl CPU transmit
  input  logic       minimig_txd,  // Minimig transmit
  input  logic       sd_dat,       // SD card MISO
  input  logic       minimig_sdo,  // Minimig SPI data out
  input  logic [3:0] spi_cs_n,     // Only bit 0 (SD card) matters here
  output key_t       key_sync,
  output logic       uart_txd,
  output logic       ctrl_rxd,
  output logic       minimig_rxd,
  output logic       spi_di,
  output logic       sd_dat3,
  output logic       scan_15khz,
  output logic       audio_swap,
  output logic       audio_mix
);

  sw_t  sw_pipe  [`BOARD_SYNC_STAGES];  // Switch sync chain
  key_t key_pipe [`BOARD_SYNC_STAGES];  // Key sync chain
  sw_t  sw_sync;
  logic uart_sel;                       // High routes UART to ctrl

  //////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      for (int i = 0; i < `BOARD_SYNC_STAGES; i++) begin
        sw_pipe[i]  <= '0;
        key_pipe[i] <= '1;  // Keys released
      end
    end else begin
      sw_pipe[0]  <= sw;
      key_pipe[0] <= key;
      for (int i = 1; i < `BOARD_SYNC_STAGES; i++) begin
        sw_pipe[i]  <= sw_pipe[i-1];
        key_pipe[i] <= key_pipe[i-1];
      end
    end
  end

  assign sw_sync  = sw_pipe[`BOARD_SYNC_STAGES-1];
  assign key_sync = key_pipe[`BOARD_SYNC_STAGES-1];

  //////////////////////////////////////////////////
  // UART and SPI routing
  //////////////////////////////////////////////////

  assign uart_sel    = sw_sync[0];
  assign uart_txd    = uart_sel ? ctrl_txd : minimig_txd;
  assign ctrl_rxd    = uart_sel ? uart_rxd : 1'b1;   // Idle line when unrouted
  assign minimig_rxd = uart_sel ? 1'b1     : uart_rxd;

  assign spi_di  = !spi_cs_n[0] ? sd_dat : minimig_sdo;  // SD card owns MISO when selected
  assign sd_dat3 = spi_cs_n[0];                          // SD chip select pin

  // Configuration switches
  assign scan_15khz = sw_sync[1];
  assign audio_swap = sw_sync[2];
  assign audio_mix  = sw_sync[3];

endmodule

// ==== verilog/board_pkg.sv ====
`include "board_defines.svh"

package board_pkg;

  // qmem bus
  typedef logic [`BOARD_AW-1:0]    qmem_adr_t;  // Byte address
  typedef logic [`BOARD_MDW-1:0]   mdat_t;      // Master data word
  typedef logic [`BOARD_MDW/8-1:0] msel_t;      // Master byte selects
  typedef logic [`BOARD_SDW-1:0]   sdat_t;      // Slave halfword
  typedef logic [`BOARD_SDW/8-1:0] ssel_t;      // Slave byte selects

  // Board I/O
  typedef logic [7:0] led_t;  // Green LEDs
  typedef logic [3:0] sw_t;   // Toggle switches
  typedef logic [1:0] key_t;  // Push buttons, low when pressed

  // Bridge sequencing
  typedef enum logic [1:0] {
    br_idle,   // Waiting for m_cs
    br_upper,  // Halfword at selects 3..2
    br_lower,  // Halfword at selects 1..0
    br_done    // m_ack cycle
  } bridge_state_t;

  typedef enum logic [1:0] {
    rs_hold,      // Everything in reset
    rs_core_run,  // Minimig core released
    rs_all_run    // CPU released too
  } rst_state_t;

endpackage

// ==== verilog/minimig_board_top.sv ====
`timescale 1ns/1ps

module minimig_board_top
  import board_pkg::*;
(
  input  logic       clk_28,
  input  logic       rst,
  input  logic       pll_locked,
  // Switches, keys, serial
  input  sw_t        sw,
  input  key_t       key,
  input  logic       uart_rxd,
  input  logic       ctrl_txd,
  input  logic       minimig_txd,
  input  logic       sd_dat,
  input  logic       minimig_sdo,
  input  logic [3:0] spi_cs_n,
  output logic       uart_txd,
  output logic       ctrl_rxd,
  output logic       minimig_rxd,
  output logic       spi_di,
  output logic       sd_dat3,
  output logic       scan_15khz,
  output logic       audio_swap,
  output logic       audio_mix,
  // Resets
  output logic       rst_sys,
  output logic       rst_minimig,
  output logic       rst_cpu,
  // qmem master side
  input  logic       m_cs,
  input  logic       m_we,
  input  qmem_adr_t  m_adr,
  input  msel_t      m_sel,
  input  mdat_t      m_dat_w,
  output mdat_t      m_dat_r,
  output logic       m_ack,
  output logic       m_err,
  // qmem slave side
  input  sdat_t      s_dat_r,
  input  logic       s_ack,
  input  logic       s_err,
  output logic       s_cs,
  output logic       s_we,
  output qmem_adr_t  s_adr,
  output ssel_t      s_sel,
  output sdat_t      s_dat_w,
  // Activity
  input  logic       floppy_fwr,
  input  logic       floppy_frd,
  input  logic       hd_fwr,
  input  logic       hd_frd,
  input  logic       fifo_full,
  output led_t       led_g
);

  key_t key_sync;  // Bit 0 is the reset key

  board_io board_io (
    .clk_28      (clk_28),
    .rst         (rst),
    .sw          (sw),
    .key         (key),
    .uart_rxd    (uart_rxd),
    .ctrl_txd    (ctrl_txd),
    .minimig_txd (minimig_txd),
    .sd_dat      (sd_dat),
    .minimig_sdo (minimig_sdo),
    .spi_cs_n    (spi_cs_n),
    .key_sync    (key_sync),
    .uart_txd    (uart_txd),
    .ctrl_rxd    (ctrl_rxd),
    .minimig_rxd (minimig_rxd),
    .spi_di      (spi_di),
    .sd_dat3     (sd_dat3),
    .scan_15khz  (scan_15khz),
    .audio_swap  (audio_swap),
    .audio_mix   (audio_mix)
  );

  reset_sequencer reset_sequencer (
    .clk_28      (clk_28),
    .rst         (rst),
    .key_n       (key_sync[0]),
    .pll_locked  (pll_locked),
    .rst_sys     (rst_sys),
    .rst_minimig (rst_minimig),
    .rst_cpu     (rst_cpu)
  );

  qmem_bridge qmem_bridge (
    .clk_28  (clk_28),
    .rst     (rst),
    .m_cs    (m_cs),
    .m_we    (m_we),
    .m_adr   (m_adr),
    .m_sel   (m_sel),
    .m_dat_w (m_dat_w),
    .m_dat_r (m_dat_r),
    .m_ack   (m_ack),
    .m_err   (m_err),
    .s_dat_r (s_dat_r),
    .s_ack   (s_ack),
    .s_err   (s_err),
    .s_cs    (s_cs),
    .s_we    (s_we),
    .s_adr   (s_adr),
    .s_sel   (s_sel),
    .s_dat_w (s_dat_w)
  );

  activity_leds activity_leds (
    .clk_28      (clk_28),
    .rst         (rst),
    .floppy_fwr  (floppy_fwr),
    .floppy_frd  (floppy_frd),
    .hd_fwr      (hd_fwr),
    .hd_frd      (hd_frd),
    .dram_active (s_cs),        // SDRAM side busy
    .rst_minimig (rst_minimig),
    .rst_cpu     (rst_cpu),
    .fifo_full   (fifo_full),
    .led_g       (led_g)
  );

endmodule

// ==== verilog/qmem_bridge.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module qmem_bridge
  import board_pkg::*;
(
  input  logic      clk_28,
  input  logic      rst,
  // 32 bit master side
  input  logic      m_cs,
  input  logic      m_we,
  input  qmem_adr_t m_adr,
  input  msel_t     m_sel,
  input  mdat_t     m_dat_w,
  output mdat_t     m_dat_r,
  output logic      m_ack,
  output logic      m_err,
  // 16 bit slave side
  input  sdat_t     s_dat_r,
  input  logic      s_ack,
  input  logic      s_err,
  output logic      s_cs,
  output logic      s_we,
  output qmem_adr_t s_adr,
  output ssel_t     s_sel,
  output sdat_t     s_dat_w
);

  localparam int mdw = `BOARD_MDW;
  localparam int sdw = `BOARD_SDW;
  localparam int msw = `BOARD_MDW / 8;
  localparam int ssw = `BOARD_SDW / 8;

  bridge_state_t state;
  qmem_adr_t     hi_adr;
  qmem_adr_t     lo_adr;
  ssel_t         hi_sel;
  ssel_t         lo_sel;
  sdat_t         hi_dat;
  sdat_t         lo_dat;

  //////////////////////////////////////////////////
  // Halfword split of the held master request
  //////////////////////////////////////////////////

  assign hi_adr = {m_adr[`BOARD_AW-1:2], 2'b00};  // Word aligned
  assign lo_adr = {m_adr[`BOARD_AW-1:2], 2'b10};  // Second halfword
  assign hi_sel = m_sel[msw-1:ssw];
  assign lo_sel = m_sel[ssw-1:0];
  assign hi_dat = m_dat_w[mdw-1:sdw];
  assign lo_dat = m_dat_w[sdw-1:0];

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      state <= br_idle;
      s_cs  <= 1'b0;
    end else begin
      case (state)
        br_idle: begin
          if (m_cs) begin
            state <= (hi_sel != '0) ? br_upper : br_lower;
            s_cs  <= (m_sel != '0);  // No slave cycle for empty selects
          end
        end
        br_upper: begin
          if (s_ack) begin
            if (lo_sel != '0) begin
              state <= br_lower;     // s_cs stays high
            end else begin
              state <= br_done;
              s_cs  <= 1'b0;
            end
          end
        end
        br_lower: begin
          if (s_ack || !s_cs) begin  // Idle pass on empty selects
            state <= br_done;
            s_cs  <= 1'b0;
          end
        end
        br_done: state <= br_idle;   // Master drops or renews m_cs here
        default: state <= br_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Slave request and master return data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    case (state)
      br_idle: begin
        if (m_cs) begin
          m_dat_r <= '0;  // Skipped halves read as zero
          m_err   <= 1'b0;
          s_we    <= m_we;
          if (hi_sel != '0) begin
            s_adr   <= hi_adr;
            s_sel   <= hi_sel;
            s_dat_w <= hi_dat;
          end else begin
            s_adr   <= lo_adr;
            s_sel   <= lo_sel;
            s_dat_w <= lo_dat;
          end
        end
      end
      br_upper: begin
        if (s_ack) begin
          m_err <= m_err | s_err;
          if (!s_we) begin
            m_dat_r[mdw-1:sdw] <= s_dat_r;
          end
          s_adr   <= lo_adr;  // Ready for the lower half
          s_sel   <= lo_sel;
          s_dat_w <= lo_dat;
        end
      end
      br_lower: begin
        if (s_ack) begin
          m_err <= m_err | s_err;
          if (!s_we) begin
            m_dat_r[sdw-1:0] <= s_dat_r;
          end
        end
      end
      default: begin
      end
    endcase
  end

  assign m_ack = (state == br_done);  // One cycle per request

endmodule

// ==== verilog/reset_sequencer.sv ====
`timescale 1ns/1ps

`include "board_defines.svh"

module reset_sequencer
  import board_pkg::*;
(
  input  logic clk_28,
  input  logic rst,
  input  logic key_n,        // Synchronized reset key, low when pressed
  input  logic pll_locked,
  output logic rst_sys,
  output logic rst_minimig,
  output logic rst_cpu
);

  localparam int hold_max = (`BOARD_RST_HOLD > `BOARD_CPU_HOLD) ?
                            `BOARD_RST_HOLD : `BOARD_CPU_HOLD;
  localparam int cnt_w    = (hold_max > 2) ? $clog2(hold_max) : 1;

  localparam logic [cnt_w-1:0] core_last = cnt_w'(`BOARD_RST_HOLD - 1);
  localparam logic [cnt_w-1:0] cpu_last  = cnt_w'(`BOARD_CPU_HOLD - 1);

  rst_state_t       state;
  logic [cnt_w-1:0] cnt;    // Cycles spent in the current stage
  logic             cause;  // Any reset source active

  assign cause = rst | ~key_n | ~pll_locked;

  always_ff @(posedge clk_28) begin
    rst_sys <= cause;  // One stage behind the causes
    if (cause) begin   // Any cause returns to hold
      state <= rs_hold;
      cnt   <= '0;
    end else begin
      case (state)
        rs_hold: begin
          if (cnt == core_last) begin  // Core hold expired
            state <= rs_core_run;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rs_core_run: begin
          if (cnt == cpu_last) begin   // CPU hold expired
            state <= rs_all_run;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rs_all_run: cnt <= '0;         // Stay until a new cause
        default:    state <= rs_hold;
      endcase
    end
  end

  assign rst_minimig = (state == rs_hold);
  assign rst_cpu     = (state != rs_all_run);

endmodule
